//--- logic/monitor_cfg_pkg.sv
/* Address map and fault codes of the order monitor.
   Slave i owns every address whose field above RegionBits equals i. */

package monitor_cfg_pkg;

  // log2 of one slave region, 64 KiB per slave
  localparam int unsigned RegionBits = 16;

  // cause of the first recorded fault
  typedef enum logic [1:0] {
    // nothing recorded yet
    err_none      = 2'd0,
    // slave command differs from the expected head
    err_mismatch  = 2'd1,
    // slave command arrived with nothing expected
    err_underflow = 2'd2,
    // master command found a selected store full
    err_overflow  = 2'd3
  } err_cause_e;

endpackage

//--- logic/axi_cmd_pkg.sv
/* AXI address channel fields kept by the monitor.
   Only address and burst length are stored; IDs and attributes are ignored. */

package axi_cmd_pkg;

  localparam int unsigned AddrWidth = 32;
  localparam int unsigned LenWidth  = 8;

  // one expectation holds address and length
  localparam int unsigned CmdWidth  = AddrWidth + LenWidth;

  // byte address of a burst
  typedef logic [AddrWidth-1:0] addr_t;

  // AXI burst length, beats minus one
  typedef logic [LenWidth-1:0]  len_t;

  // multicast mask from the AW user field
  // set bits are don't-care address bits
  typedef logic [AddrWidth-1:0] mcast_mask_t;

  // stored expectation, address in the upper bits
  typedef logic [CmdWidth-1:0]  exp_cmd_t;

endpackage

//--- logic/cmd_fifo.sv
/* Fall-through FIFO of expected commands; a push can be popped in its own cycle.
   FifoDepth is a power of two, at least 2; full_o already counts this cycle's push and pop. */
`timescale 1ns/1ps

module cmd_fifo import axi_cmd_pkg::*; #(
  parameter int unsigned FifoDepth = 8
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     push_i,
  input  logic     pop_i,
  input  exp_cmd_t data_i,
  output exp_cmd_t head_o,
  output logic     empty_o,
  output logic     full_o
);

  localparam int unsigned PtrW = $clog2(FifoDepth);
  localparam logic [PtrW:0] CntMax = (PtrW + 1)'(FifoDepth);

  exp_cmd_t        mem [FifoDepth];
  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  logic [PtrW:0]   cnt_q;
  logic [PtrW:0]   cnt_d;
  logic            stored_empty;
  logic            do_push;
  logic            do_pop;

  assign stored_empty = (cnt_q == '0);

  // incoming command bypasses the store when nothing is held
  assign head_o  = stored_empty ? data_i : mem[rd_ptr_q];
  assign empty_o = stored_empty & ~push_i;

  assign do_pop  = pop_i & ~empty_o;
  assign do_push = push_i & ((cnt_q != CntMax) | do_pop);

  always_comb begin
    cnt_d = cnt_q;
    case ({do_push, do_pop})
      2'b10:   cnt_d = cnt_q + 1'b1;
      2'b01:   cnt_d = cnt_q - 1'b1;
      default: cnt_d = cnt_q;
    endcase
  end

  // lookahead, so the router sees the fill level its next push will meet
  assign full_o = (cnt_d == CntMax);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      cnt_q <= cnt_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem[wr_ptr_q] <= data_i;
    end
  end

endmodule

//--- logic/expect_router.sv
/* Turns master AW/AR fires into per-slave expectations, one cycle later.
   Addresses outside every slave region are dropped silently; an overflow drops the whole command. */
`timescale 1ns/1ps

module expect_router import monitor_cfg_pkg::*; import axi_cmd_pkg::*; #(
  parameter  int unsigned NumSlaves = 4,
  localparam int unsigned IdxW      = (NumSlaves > 1) ? $clog2(NumSlaves) : 1
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   mst_aw_valid_i,
  input  logic                   mst_aw_ready_i,
  input  addr_t                  mst_aw_addr_i,
  input  len_t                   mst_aw_len_i,
  input  mcast_mask_t            mst_aw_mask_i,
  input  logic                   mst_ar_valid_i,
  input  logic                   mst_ar_ready_i,
  input  addr_t                  mst_ar_addr_i,
  input  len_t                   mst_ar_len_i,
  // AW stores in the low half, AR stores in the high half
  input  logic [2*NumSlaves-1:0] fifo_full_i,
  output logic [NumSlaves-1:0]   aw_push_o,
  output logic [NumSlaves-1:0]   ar_push_o,
  output exp_cmd_t               aw_cmd_o,
  output exp_cmd_t               ar_cmd_o,
  output logic                   ovf_o,
  output logic [IdxW-1:0]        ovf_slave_o
);

  localparam int unsigned FieldW = AddrWidth - RegionBits;

  logic                 aw_fire;
  logic                 ar_fire;
  logic [NumSlaves-1:0] aw_sel;
  logic [NumSlaves-1:0] ar_sel;
  logic [NumSlaves-1:0] aw_ovf_vec;
  logic [NumSlaves-1:0] ar_ovf_vec;
  logic [NumSlaves-1:0] ovf_vec;
  logic                 aw_ovf;
  logic                 ar_ovf;
  logic [IdxW-1:0]      ovf_idx;

  // a zero mask reduces this to a plain region match
  function automatic logic [NumSlaves-1:0] select_slaves(
    input addr_t       addr,
    input mcast_mask_t mask
  );
    logic [FieldW-1:0]    idx_field;
    logic [FieldW-1:0]    care;
    logic [NumSlaves-1:0] sel;
    idx_field = addr[AddrWidth-1:RegionBits];
    care      = ~mask[AddrWidth-1:RegionBits];
    for (int i = 0; i < NumSlaves; i++) begin
      sel[i] = (((idx_field ^ FieldW'(i)) & care) == '0);
    end
    return sel;
  endfunction

  assign aw_fire = mst_aw_valid_i & mst_aw_ready_i;
  assign ar_fire = mst_ar_valid_i & mst_ar_ready_i;

  // reads never multicast
  assign aw_sel = aw_fire ? select_slaves(mst_aw_addr_i, mst_aw_mask_i) : '0;
  assign ar_sel = ar_fire ? select_slaves(mst_ar_addr_i, '0) : '0;

  assign aw_ovf_vec = aw_sel & fifo_full_i[NumSlaves-1:0];
  assign ar_ovf_vec = ar_sel & fifo_full_i[2*NumSlaves-1:NumSlaves];
  assign aw_ovf     = |aw_ovf_vec;
  assign ar_ovf     = |ar_ovf_vec;

  // AW reported first, then the lowest full slave
  assign ovf_vec = aw_ovf ? aw_ovf_vec : ar_ovf_vec;

  always_comb begin
    ovf_idx = '0;
    for (int i = NumSlaves - 1; i >= 0; i--) begin
      if (ovf_vec[i]) begin
        ovf_idx = IdxW'(i);
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      aw_push_o   <= '0;
      ar_push_o   <= '0;
      ovf_o       <= 1'b0;
      ovf_slave_o <= '0;
    end else begin
      aw_push_o   <= aw_ovf ? '0 : aw_sel;
      ar_push_o   <= ar_ovf ? '0 : ar_sel;
      ovf_o       <= aw_ovf | ar_ovf;
      ovf_slave_o <= ovf_idx;
    end
  end

  always_ff @(posedge clk_i) begin
    if (aw_fire) begin
      aw_cmd_o <= {mst_aw_addr_i, mst_aw_len_i};
    end
    if (ar_fire) begin
      ar_cmd_o <= {mst_ar_addr_i, mst_ar_len_i};
    end
  end

endmodule

//--- logic/slave_order_checker.sv
/* Checks one slave port's AW and AR fires against the heads of its two stores.
   IDs are not compared; the error strobe follows the faulty fire by one cycle. */
`timescale 1ns/1ps

module slave_order_checker import monitor_cfg_pkg::*; import axi_cmd_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       aw_valid_i,
  input  logic       aw_ready_i,
  input  addr_t      aw_addr_i,
  input  len_t       aw_len_i,
  input  logic       ar_valid_i,
  input  logic       ar_ready_i,
  input  addr_t      ar_addr_i,
  input  len_t       ar_len_i,
  input  exp_cmd_t   aw_head_i,
  input  logic       aw_empty_i,
  input  exp_cmd_t   ar_head_i,
  input  logic       ar_empty_i,
  output logic       aw_pop_o,
  output logic       ar_pop_o,
  output logic       err_o,
  output err_cause_e cause_o
);

  logic       aw_fire;
  logic       ar_fire;
  err_cause_e aw_cause;
  err_cause_e ar_cause;
  err_cause_e cause_d;
  err_cause_e cause_q;

  function automatic err_cause_e check_fire(
    input logic     fire,
    input logic     empty,
    input exp_cmd_t head,
    input exp_cmd_t seen
  );
    err_cause_e cause;
    cause = err_none;
    if (fire && empty) begin
      cause = err_underflow;
    end else if (fire && (head != seen)) begin
      cause = err_mismatch;
    end
    return cause;
  endfunction

  assign aw_fire = aw_valid_i & aw_ready_i;
  assign ar_fire = ar_valid_i & ar_ready_i;

  // a mismatching head is consumed too, so later commands stay aligned
  assign aw_pop_o = aw_fire & ~aw_empty_i;
  assign ar_pop_o = ar_fire & ~ar_empty_i;

  assign aw_cause = check_fire(aw_fire, aw_empty_i, aw_head_i, {aw_addr_i, aw_len_i});
  assign ar_cause = check_fire(ar_fire, ar_empty_i, ar_head_i, {ar_addr_i, ar_len_i});

  // AW fault takes priority
  assign cause_d = (aw_cause != err_none) ? aw_cause : ar_cause;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cause_q <= err_none;
    end else begin
      cause_q <= cause_d;
    end
  end

  assign err_o   = (cause_q != err_none);
  assign cause_o = cause_q;

endmodule

//--- logic/error_log.sv
/* Holds the first fault until reset; later faults are ignored.
   Overflow beats checker faults, and among checkers the lowest slave index wins. */
`timescale 1ns/1ps

module error_log import monitor_cfg_pkg::*; #(
  parameter  int unsigned NumSlaves = 4,
  localparam int unsigned IdxW      = (NumSlaves > 1) ? $clog2(NumSlaves) : 1
) (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  logic       [NumSlaves-1:0]   chk_err_i,
  input  err_cause_e [NumSlaves-1:0]   chk_cause_i,
  input  logic                         ovf_i,
  input  logic       [IdxW-1:0]        ovf_slave_i,
  input  logic       [2*NumSlaves-1:0] fifo_empty_i,
  output logic                         error_o,
  output err_cause_e                   err_cause_o,
  output logic       [IdxW-1:0]        err_slave_o,
  output logic                         idle_o
);

  logic            hit;
  err_cause_e      hit_cause;
  logic [IdxW-1:0] hit_slave;

  assign hit = ovf_i | (|chk_err_i);

  always_comb begin
    hit_cause = err_none;
    hit_slave = '0;
    // walk downwards so the lowest faulty slave is kept
    for (int i = NumSlaves - 1; i >= 0; i--) begin
      if (chk_err_i[i]) begin
        hit_cause = chk_cause_i[i];
        hit_slave = IdxW'(i);
      end
    end
    if (ovf_i) begin
      hit_cause = err_overflow;
      hit_slave = ovf_slave_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      error_o     <= 1'b0;
      err_cause_o <= err_none;
      err_slave_o <= '0;
    end else if (!error_o && hit) begin
      error_o     <= 1'b1;
      err_cause_o <= hit_cause;
      err_slave_o <= hit_slave;
    end
  end

  // pending router pushes already show as non-empty stores
  assign idle_o = &fifo_empty_i;

endmodule

//--- logic/order_monitor_top.sv
/* Order monitor for the AW and AR channels of a multicast AXI crossbar, observe only.
   A slave fire must come at least one cycle after the master fire of the same command. */
`timescale 1ns/1ps

module order_monitor_top import monitor_cfg_pkg::*; import axi_cmd_pkg::*; #(
  parameter  int unsigned NumSlaves = 4,
  parameter  int unsigned FifoDepth = 8,
  localparam int unsigned IdxW      = (NumSlaves > 1) ? $clog2(NumSlaves) : 1
) (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    mst_aw_valid_i,
  input  logic                    mst_aw_ready_i,
  input  addr_t                   mst_aw_addr_i,
  input  len_t                    mst_aw_len_i,
  input  mcast_mask_t             mst_aw_mask_i,
  input  logic                    mst_ar_valid_i,
  input  logic                    mst_ar_ready_i,
  input  addr_t                   mst_ar_addr_i,
  input  len_t                    mst_ar_len_i,
  input  logic  [NumSlaves-1:0]   slv_aw_valid_i,
  input  logic  [NumSlaves-1:0]   slv_aw_ready_i,
  input  addr_t [NumSlaves-1:0]   slv_aw_addr_i,
  input  len_t  [NumSlaves-1:0]   slv_aw_len_i,
  input  logic  [NumSlaves-1:0]   slv_ar_valid_i,
  input  logic  [NumSlaves-1:0]   slv_ar_ready_i,
  input  addr_t [NumSlaves-1:0]   slv_ar_addr_i,
  input  len_t  [NumSlaves-1:0]   slv_ar_len_i,
  output logic                    error_o,
  output err_cause_e              err_cause_o,
  output logic  [IdxW-1:0]        err_slave_o,
  output logic                    idle_o
);

  logic       [NumSlaves-1:0]   aw_push;
  logic       [NumSlaves-1:0]   ar_push;
  exp_cmd_t                     aw_cmd;
  exp_cmd_t                     ar_cmd;
  // AW stores at index i, AR stores at NumSlaves + i
  logic       [2*NumSlaves-1:0] fifo_full;
  logic       [2*NumSlaves-1:0] fifo_empty;
  exp_cmd_t   [NumSlaves-1:0]   aw_head;
  exp_cmd_t   [NumSlaves-1:0]   ar_head;
  logic       [NumSlaves-1:0]   aw_pop;
  logic       [NumSlaves-1:0]   ar_pop;
  logic       [NumSlaves-1:0]   chk_err;
  err_cause_e [NumSlaves-1:0]   chk_cause;
  logic                         ovf;
  logic       [IdxW-1:0]        ovf_slave;

  expect_router #(
    .NumSlaves ( NumSlaves )
  ) i_expect_router (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    .mst_aw_valid_i ( mst_aw_valid_i ),
    .mst_aw_ready_i ( mst_aw_ready_i ),
    .mst_aw_addr_i  ( mst_aw_addr_i  ),
    .mst_aw_len_i   ( mst_aw_len_i   ),
    .mst_aw_mask_i  ( mst_aw_mask_i  ),
    .mst_ar_valid_i ( mst_ar_valid_i ),
    .mst_ar_ready_i ( mst_ar_ready_i ),
    .mst_ar_addr_i  ( mst_ar_addr_i  ),
    .mst_ar_len_i   ( mst_ar_len_i   ),
    .fifo_full_i    ( fifo_full      ),
    .aw_push_o      ( aw_push        ),
    .ar_push_o      ( ar_push        ),
    .aw_cmd_o       ( aw_cmd         ),
    .ar_cmd_o       ( ar_cmd         ),
    .ovf_o          ( ovf            ),
    .ovf_slave_o    ( ovf_slave      )
  );

  for (genvar i = 0; i < NumSlaves; i++) begin : gen_slave
    cmd_fifo #(
      .FifoDepth ( FifoDepth )
    ) i_aw_fifo (
      .clk_i   ( clk_i         ),
      .rst_n_i ( rst_n_i       ),
      .push_i  ( aw_push[i]    ),
      .pop_i   ( aw_pop[i]     ),
      .data_i  ( aw_cmd        ),
      .head_o  ( aw_head[i]    ),
      .empty_o ( fifo_empty[i] ),
      .full_o  ( fifo_full[i]  )
    );

    cmd_fifo #(
      .FifoDepth ( FifoDepth )
    ) i_ar_fifo (
      .clk_i   ( clk_i                     ),
      .rst_n_i ( rst_n_i                   ),
      .push_i  ( ar_push[i]                ),
      .pop_i   ( ar_pop[i]                 ),
      .data_i  ( ar_cmd                    ),
      .head_o  ( ar_head[i]                ),
      .empty_o ( fifo_empty[NumSlaves + i] ),
      .full_o  ( fifo_full[NumSlaves + i]  )
    );

    slave_order_checker i_checker (
      .clk_i      ( clk_i                     ),
      .rst_n_i    ( rst_n_i                   ),
      .aw_valid_i ( slv_aw_valid_i[i]         ),
      .aw_ready_i ( slv_aw_ready_i[i]         ),
      .aw_addr_i  ( slv_aw_addr_i[i]          ),
      .aw_len_i   ( slv_aw_len_i[i]           ),
      .ar_valid_i ( slv_ar_valid_i[i]         ),
      .ar_ready_i ( slv_ar_ready_i[i]         ),
      .ar_addr_i  ( slv_ar_addr_i[i]          ),
      .ar_len_i   ( slv_ar_len_i[i]           ),
      .aw_head_i  ( aw_head[i]                ),
      .aw_empty_i ( fifo_empty[i]             ),
      .ar_head_i  ( ar_head[i]                ),
      .ar_empty_i ( fifo_empty[NumSlaves + i] ),
      .aw_pop_o   ( aw_pop[i]                 ),
      .ar_pop_o   ( ar_pop[i]                 ),
      .err_o      ( chk_err[i]                ),
      .cause_o    ( chk_cause[i]              )
    );
  end

  error_log #(
    .NumSlaves ( NumSlaves )
  ) i_error_log (
    .clk_i        ( clk_i       ),
    .rst_n_i      ( rst_n_i     ),
    .chk_err_i    ( chk_err     ),
    .chk_cause_i  ( chk_cause   ),
    .ovf_i        ( ovf         ),
    .ovf_slave_i  ( ovf_slave   ),
    .fifo_empty_i ( fifo_empty  ),
    .error_o      ( error_o     ),
    .err_cause_o  ( err_cause_o ),
    .err_slave_o  ( err_slave_o ),
    .idle_o       ( idle_o      )
  );

endmodule

//--- bench/order_monitor_assertions.sv
/* Reporting rules of the order monitor, bound into order_monitor_top.
   Reported values are not checked here; fail_count exposes failed rules. */
`timescale 1ns/1ps

module order_monitor_assertions import monitor_cfg_pkg::*; (
  input logic       clk_i,
  input logic       rst_n_i,
  input logic       error_i,
  input err_cause_e err_cause_i,
  input logic       idle_i
);

  int unsigned fail_count = 0;

  // first fault sticks until reset
  error_sticky: assert property (@(posedge clk_i) disable iff (!rst_n_i) error_i |=> error_i)
    else begin
      fail_count++;
      $error("error_o fell without a reset");
    end

  // a raised error always carries a cause
  error_has_cause: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) error_i |-> (err_cause_i != err_none))
    else begin
      fail_count++;
      $error("error_o is high while err_cause_o is err_none");
    end

  // first cycle out of reset
  reset_state: assert property (@(posedge clk_i) $rose(rst_n_i) |-> (idle_i && !error_i))
    else begin
      fail_count++;
      $error("monitor is not idle and error free after reset release");
    end

endmodule

bind order_monitor_top order_monitor_assertions i_order_monitor_assertions (
  .clk_i       ( clk_i       ),
  .rst_n_i     ( rst_n_i     ),
  .error_i     ( error_o     ),
  .err_cause_i ( err_cause_o ),
  .idle_i      ( idle_o      )
);

//--- bench/tb_order_monitor.sv
/* Testbench of the order monitor with 4 slaves and 8-deep stores.
   Inputs change 1 ns after the rising edge; outputs are sampled there too. */
`timescale 1ns/1ps

module tb_order_monitor import monitor_cfg_pkg::*; import axi_cmd_pkg::*; ();

  localparam int NumSlv  = 4;
  localparam int Depth   = 8;
  localparam int Timeout = 50;

  logic clk = 1'b0;
  logic rst_n;
  logic mst_aw_valid, mst_aw_ready, mst_ar_valid, mst_ar_ready;
  addr_t mst_aw_addr, mst_ar_addr;
  len_t mst_aw_len, mst_ar_len;
  mcast_mask_t mst_aw_mask;
  logic [NumSlv-1:0] slv_aw_valid, slv_aw_ready, slv_ar_valid, slv_ar_ready;
  addr_t [NumSlv-1:0] slv_aw_addr, slv_ar_addr;
  len_t [NumSlv-1:0] slv_aw_len, slv_ar_len;
  logic err_flag;
  err_cause_e err_cause;
  logic [1:0] err_slave;
  logic idle;

  integer seed = 32'h56857bf6;
  // expected order per slave port
  exp_cmd_t aw_q [NumSlv][$];
  exp_cmd_t ar_q [NumSlv][$];

  order_monitor_top #(
    .NumSlaves ( NumSlv ),
    .FifoDepth ( Depth  )
  ) i_order_monitor_top (
    .clk_i          ( clk          ),
    .rst_n_i        ( rst_n        ),
    .mst_aw_valid_i ( mst_aw_valid ),
    .mst_aw_ready_i ( mst_aw_ready ),
    .mst_aw_addr_i  ( mst_aw_addr  ),
    .mst_aw_len_i   ( mst_aw_len   ),
    .mst_aw_mask_i  ( mst_aw_mask  ),
    .mst_ar_valid_i ( mst_ar_valid ),
    .mst_ar_ready_i ( mst_ar_ready ),
    .mst_ar_addr_i  ( mst_ar_addr  ),
    .mst_ar_len_i   ( mst_ar_len   ),
    .slv_aw_valid_i ( slv_aw_valid ),
    .slv_aw_ready_i ( slv_aw_ready ),
    .slv_aw_addr_i  ( slv_aw_addr  ),
    .slv_aw_len_i   ( slv_aw_len   ),
    .slv_ar_valid_i ( slv_ar_valid ),
    .slv_ar_ready_i ( slv_ar_ready ),
    .slv_ar_addr_i  ( slv_ar_addr  ),
    .slv_ar_len_i   ( slv_ar_len   ),
    .error_o        ( err_flag     ),
    .err_cause_o    ( err_cause    ),
    .err_slave_o    ( err_slave    ),
    .idle_o         ( idle         )
  );

  always #5 clk = ~clk;

  task automatic stop_on_failure(input string reason);
    $display("%s", reason);
    $display("Simulation failed");
    $fatal(1);
  endtask

  // a bound rule that fails ends the run as well
  always @(negedge clk) begin
    if (i_order_monitor_top.i_order_monitor_assertions.fail_count != 0) begin
      stop_on_failure("a bound assertion on the reporting rules failed");
    end
  end

  task automatic check_value(input string test, input int expected, input int actual);
    if (expected != actual) begin
      stop_on_failure($sformatf("** Error: %s expected %0d actual %0d", test, expected, actual));
    end
  endtask

  task automatic clear_inputs();
    {mst_aw_valid, mst_aw_ready, mst_ar_valid, mst_ar_ready} = '0;
    mst_aw_addr  = '0;
    mst_aw_len   = '0;
    mst_aw_mask  = '0;
    mst_ar_addr  = '0;
    mst_ar_len   = '0;
    {slv_aw_valid, slv_aw_ready, slv_ar_valid, slv_ar_ready} = '0;
    {slv_aw_addr, slv_aw_len, slv_ar_addr, slv_ar_len} = '0;
  endtask

  task automatic reset_and_check(input string test);
    rst_n = 1'b0;
    clear_inputs();
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(posedge clk);
    #1;
    check_value({test, "_error"}, 0, int'(err_flag));
    check_value({test, "_cause"}, int'(err_none), int'(err_cause));
    check_value({test, "_slave"}, 0, int'(err_slave));
    check_value({test, "_idle"}, 1, int'(idle));
  endtask

  // address inside the region of one slave
  function automatic exp_cmd_t random_cmd(input int slave);
    addr_t addr;
    len_t  len;
    addr = (addr_t'(slave) << RegionBits) | (addr_t'($random(seed)) & 32'h0000_ffff);
    len  = len_t'($random(seed));
    return {addr, len};
  endfunction

  task automatic master_fire(input logic aw_en, input exp_cmd_t aw_cmd, input mcast_mask_t mask,
                             input logic ar_en, input exp_cmd_t ar_cmd);
    {mst_aw_valid, mst_aw_ready} = {2{aw_en}};
    {mst_aw_addr, mst_aw_len}    = aw_cmd;
    mst_aw_mask                  = mask;
    {mst_ar_valid, mst_ar_ready} = {2{ar_en}};
    {mst_ar_addr, mst_ar_len}    = ar_cmd;
    @(posedge clk);
    #1;
    clear_inputs();
  endtask

  task automatic slave_fire(input int s, input logic aw_en, input exp_cmd_t aw_cmd,
                            input logic ar_en, input exp_cmd_t ar_cmd);
    slv_aw_valid[s] = aw_en;
    slv_aw_ready[s] = aw_en;
    {slv_aw_addr[s], slv_aw_len[s]} = aw_cmd;
    slv_ar_valid[s] = ar_en;
    slv_ar_ready[s] = ar_en;
    {slv_ar_addr[s], slv_ar_len[s]} = ar_cmd;
    @(posedge clk);
    #1;
    clear_inputs();
  endtask

  task automatic wait_idle(input string test);
    int cycles;
    cycles = 0;
    while (!idle && cycles < Timeout) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (!idle) stop_on_failure($sformatf("%s: timeout while waiting for idle_o", test));
  endtask

  task automatic wait_error(input string test);
    int cycles;
    cycles = 0;
    while (!err_flag && cycles < Timeout) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (!err_flag) stop_on_failure($sformatf("%s: timeout while waiting for error_o", test));
  endtask

  // replays every queued command at its own slave port
  task automatic drain_queues();
    exp_cmd_t aw_cmd;
    exp_cmd_t ar_cmd;
    logic     aw_en;
    logic     ar_en;
    for (int s = 0; s < NumSlv; s++) begin
      while (aw_q[s].size() > 0 || ar_q[s].size() > 0) begin
        aw_en  = (aw_q[s].size() > 0);
        ar_en  = (ar_q[s].size() > 0);
        aw_cmd = '0;
        ar_cmd = '0;
        if (aw_en) aw_cmd = aw_q[s].pop_front();
        if (ar_en) ar_cmd = ar_q[s].pop_front();
        slave_fire(s, aw_en, aw_cmd, ar_en, ar_cmd);
      end
    end
  endtask

  task automatic run_unicast();
    exp_cmd_t aw_cmd;
    exp_cmd_t ar_cmd;
    int       aw_slv;
    int       ar_slv;
    for (int n = 0; n < 20; n++) begin
      aw_slv = int'($unsigned($random(seed)) % NumSlv);
      ar_slv = int'($unsigned($random(seed)) % NumSlv);
      aw_cmd = random_cmd(aw_slv);
      ar_cmd = random_cmd(ar_slv);
      aw_q[aw_slv].push_back(aw_cmd);
      ar_q[ar_slv].push_back(ar_cmd);
      master_fire(1'b1, aw_cmd, '0, 1'b1, ar_cmd);
      // never more than 5 outstanding per store
      if (n % 5 == 4) drain_queues();
    end
    wait_idle("unicast_idle");
    repeat (2) @(posedge clk);
    #1;
    check_value("unicast_error", 0, int'(err_flag));
  endtask

  task automatic run_multicast();
    exp_cmd_t    cmd;
    mcast_mask_t mask;
    // index bit 0 ignored, so region 2 reaches slaves 2 and 3
    mask = mcast_mask_t'(1) << RegionBits;
    cmd  = random_cmd(2);
    master_fire(1'b1, cmd, mask, 1'b0, '0);
    slave_fire(2, 1'b1, cmd, 1'b0, '0);
    slave_fire(3, 1'b1, cmd, 1'b0, '0);
    wait_idle("multicast_idle");
    repeat (2) @(posedge clk);
    #1;
    check_value("multicast_error", 0, int'(err_flag));
    reset_and_check("multicast_reset");
    master_fire(1'b1, cmd, mask, 1'b0, '0);
    slave_fire(0, 1'b1, cmd, 1'b0, '0);
    wait_error("underflow_wait");
    check_value("underflow_cause", int'(err_underflow), int'(err_cause));
    check_value("underflow_slave", 0, int'(err_slave));
    reset_and_check("underflow_reset");
  endtask

  task automatic run_mismatch();
    exp_cmd_t cmd;
    cmd = random_cmd(1);
    master_fire(1'b1, cmd, '0, 1'b0, '0);
    // length LSB flipped
    slave_fire(1, 1'b1, cmd ^ exp_cmd_t'(1), 1'b0, '0);
    // checker register, then the log register
    check_value("mismatch_latency_first", 0, int'(err_flag));
    @(posedge clk);
    #1;
    check_value("mismatch_latency_second", 1, int'(err_flag));
    check_value("mismatch_cause", int'(err_mismatch), int'(err_cause));
    check_value("mismatch_slave", 1, int'(err_slave));
    reset_and_check("mismatch_reset");
  endtask

  task automatic run_overflow();
    for (int k = 0; k < Depth + 1; k++) begin
      master_fire(1'b1, random_cmd(2), '0, 1'b0, '0);
    end
    wait_error("overflow_wait");
    check_value("overflow_cause", int'(err_overflow), int'(err_cause));
    check_value("overflow_slave", 2, int'(err_slave));
    reset_and_check("overflow_reset");
  endtask

  initial begin
    reset_and_check("initial_reset");
    run_unicast();
    run_multicast();
    run_mismatch();
    run_overflow();
    if (i_order_monitor_top.i_order_monitor_assertions.fail_count == 0) begin
      $display("Simulation completed successfully");
      $finish;
    end else begin
      stop_on_failure("a bound assertion on the reporting rules failed");
    end
  end

endmodule

//--- order_monitor.f
logic/monitor_cfg_pkg.sv
logic/axi_cmd_pkg.sv
logic/cmd_fifo.sv
logic/expect_router.sv
logic/slave_order_checker.sv
logic/error_log.sv
logic/order_monitor_top.sv
bench/order_monitor_assertions.sv
bench/tb_order_monitor.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the order monitor testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 --top-module tb_order_monitor -f order_monitor.f \
  || { echo "Verilator build failed"; exit 1; }
# error limit above one lets the testbench see a failed bound assertion
sim_out=$(./obj_dir/Vtb_order_monitor +verilator+error+limit+10 2>&1)
echo "$sim_out"
echo "$sim_out" | grep -qx "Simulation completed successfully" && exit 0 || exit 1
